/* flist.f */
source/cdp_rdma_cfg_pkg.sv
source/cdp_rdma_types_pkg.sv
source/cdp_rdma_pos_if.sv
source/cdp_rdma_op_ctrl.sv
source/cdp_rdma_cube_walker.sv
source/cdp_rdma_addr_gen.sv
source/cdp_rdma_stall_perf.sv
source/cdp_rdma_ig.sv
tb/cdp_rdma_ig_tb.sv

/* Bender.yml */
package:
  name: cdp_rdma_ig

sources:
  - files:
      - source/cdp_rdma_cfg_pkg.sv
      - source/cdp_rdma_types_pkg.sv
      - source/cdp_rdma_pos_if.sv
      - source/cdp_rdma_op_ctrl.sv
      - source/cdp_rdma_cube_walker.sv
      - source/cdp_rdma_addr_gen.sv
      - source/cdp_rdma_stall_perf.sv
      - source/cdp_rdma_ig.sv
  - target: test
    files:
      - tb/cdp_rdma_ig_tb.sv

/* tb/cdp_rdma_ig_tb.sv */
// read dma ingress testbench
`timescale 1ns/10ps

module cdp_rdma_ig_tb;
  import cdp_rdma_types_pkg::*;

  logic        nvdla_core_clk;
  logic        nvdla_core_rstn;
  logic        reg2dp_op_en;
  logic        reg2dp_dma_en;
  logic [12:0] reg2dp_width;
  logic [12:0] reg2dp_height;
  logic [12:0] reg2dp_channel;
  logic [31:0] reg2dp_src_base_addr_high;
  logic [31:0] reg2dp_src_base_addr_low;
  logic [31:0] reg2dp_src_line_stride;
  logic [31:0] reg2dp_src_surface_stride;
  logic        eg2ig_done;
  logic        dma_rd_req_valid;
  logic        dma_rd_req_ready;
  dma_req_t    dma_rd_req_pd;
  logic        cq_wr_pvld;
  logic        cq_wr_prdy;
  cq_entry_t   cq_wr_pd;
  logic [31:0] dp2reg_d0_perf_read_stall;
  logic [31:0] dp2reg_d1_perf_read_stall;

  // layer configs: width, height, channel fields and base
  int          cfg_w [6] = '{5, 20, 12, 20, 9, 30};
  int          cfg_h [6] = '{3, 2, 1, 2, 1, 2};
  int          cfg_c [6] = '{95, 63, 31, 63, 32, 95};
  logic [63:0] cfg_base [6] = '{64'h0000_0001_0000_0000, 64'h0000_0000_8000_0000,
                                64'h0000_0002_0004_0000, 64'h0000_0000_0100_0000,
                                64'h0000_0003_0000_0000, 64'h0000_0004_5000_0000};

  // model of the layer control and stall counter
  logic        exp_run = 1'b0;
  logic        exp_drain = 1'b0;
  logic        exp_valid;
  logic        exp_acc;
  logic        perf_sel = 1'b0;
  logic [31:0] exp_perf [2] = '{32'd0, 32'd0};
  int          layer_stalls = 0;
  int          req_idx = 0;
  int          layer_total = 1;
  int          rdy_mode = 0;
  int          dma_cnt = 0;
  int          cq_cnt = 0;
  dma_req_t    exp_req;
  cq_entry_t   exp_ent;

  int          err_cnt = 0;
  int          check_cnt = 0;
  int          tests_run = 0;
  int          err_mark;
  int          limit_cycles;

  cdp_rdma_ig dut_i (.*);

  always #4 nvdla_core_clk = ~nvdla_core_clk;

  // ==============================
  // reference model
  // ==============================
  function automatic int req_count(input int w, input int h, input int c);
    return ((c >> 5) + 1) * ((w + 8) / 8) * (h + 1);
  endfunction

  // request n of the current layer, channel groups innermost
  function automatic void expected_step(input int n, output dma_req_t req,
                                        output cq_entry_t ent);
    int         nc;
    int         nb;
    int         nh;
    int         c;
    int         b;
    int         h;
    logic [2:0] sz;
    nc = (reg2dp_channel >> 5) + 1;
    nb = (reg2dp_width + 8) / 8;
    nh = reg2dp_height + 1;
    c  = n % nc;
    b  = (n / nc) % nb;
    h  = n / (nc * nb);
    // tail block carries the low width bits
    sz = (b == nb - 1) ? reg2dp_width[2:0] : 3'd7;
    req.size = 15'(sz);
    req.addr = {reg2dp_src_base_addr_high, reg2dp_src_base_addr_low}
             + 64'(h) * 64'(reg2dp_src_line_stride) + 64'(b) * 64'd256
             + 64'(c) * 64'(reg2dp_src_surface_stride);
    ent.last_c = (c == nc - 1);
    ent.last_h = (h == nh - 1);
    ent.last_w = (b == nb - 1);
    ent.align  = 1'b0;
    ent.size   = sz;
  endfunction

  task automatic check_val(input string name, input logic [127:0] got,
                           input logic [127:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  // ==============================
  // ready driver
  // ==============================
  always @(posedge nvdla_core_clk) begin
    case (rdy_mode)
      1: begin
        dma_rd_req_ready <= ($urandom % 4) != 0;
        cq_wr_prdy       <= ($urandom % 4) != 0;
      end
      // queue stalls often
      2: begin
        dma_rd_req_ready <= ($urandom % 4) != 0;
        cq_wr_prdy       <= ($urandom % 2) != 0;
      end
      default: begin
        dma_rd_req_ready <= 1'b1;
        cq_wr_prdy       <= 1'b1;
      end
    endcase
  end

  // ==============================
  // checker
  // ==============================
  always @(posedge nvdla_core_clk) begin
    if (nvdla_core_rstn) begin
      exp_valid = exp_run && cq_wr_prdy;
      exp_acc   = exp_valid && dma_rd_req_ready;
      check_val("dma_rd_req_valid", dma_rd_req_valid, exp_valid);
      check_val("cq_wr_pvld", cq_wr_pvld, exp_run && dma_rd_req_ready);
      // both channels take the same step
      check_val("cq accept vs dma accept", cq_wr_pvld && cq_wr_prdy,
                dma_rd_req_valid && dma_rd_req_ready);
      if (dma_rd_req_valid && dma_rd_req_ready) dma_cnt <= dma_cnt + 1;
      if (cq_wr_pvld && cq_wr_prdy) cq_cnt <= cq_cnt + 1;
      if (exp_acc) begin
        expected_step(req_idx, exp_req, exp_ent);
        check_val("dma_rd_req_pd", dma_rd_req_pd, exp_req);
        check_val("cq_wr_pd", cq_wr_pd, exp_ent);
        if (req_idx == layer_total - 1) begin
          // cube end, snapshot this layer's stalls
          exp_run            <= 1'b0;
          exp_drain          <= 1'b1;
          req_idx            <= 0;
          exp_perf[perf_sel] <= layer_stalls;
          layer_stalls       <= 0;
          perf_sel           <= ~perf_sel;
        end else begin
          req_idx <= req_idx + 1;
        end
      end else if (reg2dp_dma_en && exp_valid && !dma_rd_req_ready) begin
        layer_stalls <= layer_stalls + 1;
      end
      if (!exp_run && !exp_drain && reg2dp_op_en) exp_run <= 1'b1;
      if (exp_drain && eg2ig_done) exp_drain <= 1'b0;
    end
  end

  // ==============================
  // test tasks
  // ==============================
  task automatic apply_cfg(input int idx, input int mode, input logic dma_en);
    @(posedge nvdla_core_clk);
    reg2dp_width              <= cfg_w[idx];
    reg2dp_height             <= cfg_h[idx];
    reg2dp_channel            <= cfg_c[idx];
    reg2dp_src_base_addr_high <= cfg_base[idx][63:32];
    reg2dp_src_base_addr_low  <= cfg_base[idx][31:0];
    reg2dp_dma_en             <= dma_en;
    rdy_mode                  <= mode;
    layer_total               <= req_count(cfg_w[idx], cfg_h[idx], cfg_c[idx]);
  endtask

  // run one layer up to drain, optionally close it out
  task automatic issue_layer(input logic hold_en);
    int dma_start;
    int cq_start;
    dma_start = dma_cnt;
    cq_start  = cq_cnt;
    @(posedge nvdla_core_clk);
    reg2dp_op_en <= 1'b1;
    while (!exp_drain) @(posedge nvdla_core_clk);
    check_val("dma request count", dma_cnt - dma_start, layer_total);
    check_val("cq entry count", cq_cnt - cq_start, layer_total);
    check_val("dp2reg_d0_perf_read_stall", dp2reg_d0_perf_read_stall, exp_perf[0]);
    check_val("dp2reg_d1_perf_read_stall", dp2reg_d1_perf_read_stall, exp_perf[1]);
    if (!hold_en) begin
      reg2dp_op_en <= 1'b0;
      repeat (3) @(posedge nvdla_core_clk);
      eg2ig_done <= 1'b1;
      @(posedge nvdla_core_clk);
      eg2ig_done <= 1'b0;
    end
  endtask

  task automatic report(input int num, input string name);
    tests_run++;
    $display("test %0d %s: %s", num, name, (err_cnt == err_mark) ? "passed" : "failed");
    err_mark = err_cnt;
  endtask

  // ==============================
  // watchdog
  // ==============================
  initial begin
    limit_cycles = 500;
    for (int i = 0; i < 6; i++) begin
      limit_cycles += 20 * req_count(cfg_w[i], cfg_h[i], cfg_c[i]);
    end
    repeat (limit_cycles) @(posedge nvdla_core_clk);
    $display("timeout: layers not finished after %0d cycles", limit_cycles);
    $display("** FAIL **");
    $finish;
  end

  // ==============================
  // main sequence
  // ==============================
  initial begin
    void'($urandom(32'h37435ff7));
    nvdla_core_clk            = 1'b0;
    nvdla_core_rstn           = 1'b0;
    reg2dp_op_en              = 1'b0;
    reg2dp_dma_en             = 1'b1;
    reg2dp_width              = '0;
    reg2dp_height             = '0;
    reg2dp_channel            = '0;
    reg2dp_src_base_addr_high = '0;
    reg2dp_src_base_addr_low  = '0;
    reg2dp_src_line_stride    = 32'h0000_4000;
    reg2dp_src_surface_stride = 32'h0010_0000;
    eg2ig_done                = 1'b0;
    dma_rd_req_ready          = 1'b1;
    cq_wr_prdy                = 1'b1;
    err_mark                  = 0;
    repeat (10) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;

    apply_cfg(0, 0, 1'b1);
    issue_layer(1'b0);
    report(1, "single block row");
    apply_cfg(1, 1, 1'b1);
    issue_layer(1'b0);
    report(2, "multi block row, random ready");
    // stall counting off for this layer
    apply_cfg(2, 2, 1'b0);
    issue_layer(1'b0);
    report(3, "joint handshake");
    apply_cfg(3, 1, 1'b1);
    issue_layer(1'b0);
    report(4, "stall counters");

    // op_en held, no egress done yet
    apply_cfg(4, 1, 1'b1);
    issue_layer(1'b1);
    repeat (8) @(posedge nvdla_core_clk);
    apply_cfg(5, 1, 1'b1);
    @(posedge nvdla_core_clk);
    eg2ig_done <= 1'b1;
    @(posedge nvdla_core_clk);
    eg2ig_done <= 1'b0;
    issue_layer(1'b0);
    report(5, "layer gating");

    repeat (4) @(posedge nvdla_core_clk);
    $display("tests %0d, checks %0d, errors %0d", tests_run, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* source/cdp_rdma_ig.sv */
// cdp read dma ingress top
`timescale 1ns/10ps

module cdp_rdma_ig (
  input  logic                                 nvdla_core_clk,
  input  logic                                 nvdla_core_rstn,
  // register config
  input  logic                                 reg2dp_op_en,
  input  logic                                 reg2dp_dma_en,
  input  logic [cdp_rdma_cfg_pkg::dim_w-1:0]   reg2dp_width,
  input  logic [cdp_rdma_cfg_pkg::dim_w-1:0]   reg2dp_height,
  input  logic [cdp_rdma_cfg_pkg::dim_w-1:0]   reg2dp_channel,
  input  logic [31:0]                          reg2dp_src_base_addr_high,
  input  logic [31:0]                          reg2dp_src_base_addr_low,
  input  logic [31:0]                          reg2dp_src_line_stride,
  input  logic [31:0]                          reg2dp_src_surface_stride,
  // egress side
  input  logic                                 eg2ig_done,
  // dma read request
  output logic                                 dma_rd_req_valid,
  input  logic                                 dma_rd_req_ready,
  output cdp_rdma_types_pkg::dma_req_t         dma_rd_req_pd,
  // context queue write
  output logic                                 cq_wr_pvld,
  input  logic                                 cq_wr_prdy,
  output cdp_rdma_types_pkg::cq_entry_t        cq_wr_pd,
  // perf registers
  output logic [cdp_rdma_cfg_pkg::stall_w-1:0] dp2reg_d0_perf_read_stall,
  output logic [cdp_rdma_cfg_pkg::stall_w-1:0] dp2reg_d1_perf_read_stall
);
  import cdp_rdma_cfg_pkg::*;

  logic              accept;
  logic              load;
  logic              layer_done;
  logic [addr_w-1:0] base_addr;
  logic [addr_w-1:0] req_addr;

  cdp_rdma_pos_if pos ();

  // 64 bit source base
  assign base_addr = {reg2dp_src_base_addr_high, reg2dp_src_base_addr_low};

  // ==============================
  // control and walk
  // ==============================
  cdp_rdma_op_ctrl u_op_ctrl (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_en           (reg2dp_op_en),
    .eg2ig_done      (eg2ig_done),
    .dma_ready       (dma_rd_req_ready),
    .cq_ready        (cq_wr_prdy),
    .pos             (pos.user),
    .dma_valid       (dma_rd_req_valid),
    .cq_valid        (cq_wr_pvld),
    .accept          (accept),
    .load            (load),
    .layer_done      (layer_done)
  );

  cdp_rdma_cube_walker u_cube_walker (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .accept          (accept),
    .width           (reg2dp_width),
    .height          (reg2dp_height),
    .channel         (reg2dp_channel),
    .pos             (pos.walker)
  );

  cdp_rdma_addr_gen u_addr_gen (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .load            (load),
    .accept          (accept),
    .base_addr       (base_addr),
    .line_stride     (reg2dp_src_line_stride),
    .surf_stride     (reg2dp_src_surface_stride),
    .pos             (pos.user),
    .req_addr        (req_addr)
  );

  cdp_rdma_stall_perf u_stall_perf (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .dma_en          (reg2dp_dma_en),
    .dma_valid       (dma_rd_req_valid),
    .dma_ready       (dma_rd_req_ready),
    .layer_done      (layer_done),
    .perf_stall_d0   (dp2reg_d0_perf_read_stall),
    .perf_stall_d1   (dp2reg_d1_perf_read_stall)
  );

  // ==============================
  // payload packing
  // ==============================
  // size in atoms minus one
  assign dma_rd_req_pd.size = size_w'(pos.blk_size);
  assign dma_rd_req_pd.addr = req_addr;

  // where this request sits in the cube
  assign cq_wr_pd.last_c = pos.last_c;
  assign cq_wr_pd.last_h = pos.last_h;
  assign cq_wr_pd.last_w = pos.last_w;
  // alignment not tracked
  assign cq_wr_pd.align  = 1'b0;
  assign cq_wr_pd.size   = pos.blk_size;

endmodule

/* source/cdp_rdma_stall_perf.sv */
// read stall performance counter
`timescale 1ns/10ps

module cdp_rdma_stall_perf (
  input  logic                                 nvdla_core_clk,
  input  logic                                 nvdla_core_rstn,
  input  logic                                 dma_en,
  input  logic                                 dma_valid,
  input  logic                                 dma_ready,
  input  logic                                 layer_done,
  output logic [cdp_rdma_cfg_pkg::stall_w-1:0] perf_stall_d0,
  output logic [cdp_rdma_cfg_pkg::stall_w-1:0] perf_stall_d1
);
  import cdp_rdma_cfg_pkg::*;

  logic [stall_w-1:0] stall_cnt;
  logic               stall;
  // selects d1 when set
  logic               layer_flag;

  // request held back by the dma
  assign stall = dma_en & dma_valid & ~dma_ready;

  // ==============================
  // stall counter
  // ==============================
  // cleared per layer
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      stall_cnt <= '0;
    end else if (layer_done) begin
      stall_cnt <= '0;
    end else if (stall) begin
      stall_cnt <= stall_cnt + 1'b1;
    end
  end

  // ==============================
  // ping-pong snapshot
  // ==============================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      layer_flag    <= 1'b0;
      perf_stall_d0 <= '0;
      perf_stall_d1 <= '0;
    end else if (layer_done) begin
      layer_flag <= ~layer_flag;
      if (layer_flag) begin
        perf_stall_d1 <= stall_cnt;
      end else begin
        perf_stall_d0 <= stall_cnt;
      end
    end
  end

endmodule

/* source/cdp_rdma_addr_gen.sv */
// request address generator
`timescale 1ns/10ps

module cdp_rdma_addr_gen (
  input  logic                                nvdla_core_clk,
  input  logic                                nvdla_core_rstn,
  input  logic                                load,
  input  logic                                accept,
  input  logic [cdp_rdma_cfg_pkg::addr_w-1:0] base_addr,
  input  logic [31:0]                         line_stride,
  input  logic [31:0]                         surf_stride,
  cdp_rdma_pos_if.user                        pos,
  output logic [cdp_rdma_cfg_pkg::addr_w-1:0] req_addr
);
  import cdp_rdma_cfg_pkg::*;

  logic [addr_w-1:0] line_addr;
  logic [addr_w-1:0] blk_addr;
  logic [addr_w:0]   surf_sum;
  logic [addr_w:0]   blk_sum;
  logic [addr_w:0]   line_sum;
  logic [w_block_atoms_log2:0] blk_atoms;

  // ==============================
  // next addresses, carry on top
  // ==============================
  // next channel group in same block
  assign surf_sum  = {1'b0, req_addr} + (addr_w + 1)'(surf_stride);
  // next block in the line
  assign blk_atoms = {1'b0, pos.blk_size} + 1'b1;
  assign blk_sum   = {1'b0, blk_addr} + ((addr_w + 1)'(blk_atoms) << atom_bytes_log2);
  // next line
  assign line_sum  = {1'b0, line_addr} + (addr_w + 1)'(line_stride);

  // ==============================
  // address registers
  // ==============================
  always_ff @(posedge nvdla_core_clk) begin
    if (load) begin
      line_addr <= base_addr;
      blk_addr  <= base_addr;
      req_addr  <= base_addr;
    end else if (accept) begin
      if (!pos.last_c) begin
        req_addr <= surf_sum[addr_w-1:0];
      end else if (!pos.last_w) begin
        blk_addr <= blk_sum[addr_w-1:0];
        req_addr <= blk_sum[addr_w-1:0];
      end else begin
        // row done, all three move to the new line
        line_addr <= line_sum[addr_w-1:0];
        blk_addr  <= line_sum[addr_w-1:0];
        req_addr  <= line_sum[addr_w-1:0];
      end
    end
  end

  // no wrap past the top of memory
  a_surf_no_carry: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (accept && !load && !pos.last_c) |-> !surf_sum[addr_w]
  );
  a_blk_no_carry: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (accept && !load && pos.last_c && !pos.last_w) |-> !blk_sum[addr_w]
  );
  a_line_no_carry: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (accept && !load && pos.last_c && pos.last_w) |-> !line_sum[addr_w]
  );

endmodule

/* source/cdp_rdma_cube_walker.sv */
// input cube walker
`timescale 1ns/10ps

module cdp_rdma_cube_walker (
  input  logic                             nvdla_core_clk,
  input  logic                             nvdla_core_rstn,
  input  logic                             accept,
  input  logic [cdp_rdma_cfg_pkg::dim_w-1:0] width,
  input  logic [cdp_rdma_cfg_pkg::dim_w-1:0] height,
  input  logic [cdp_rdma_cfg_pkg::dim_w-1:0] channel,
  cdp_rdma_pos_if.walker                   pos
);
  import cdp_rdma_cfg_pkg::*;

  logic [c_cnt_w-1:0] c_cnt;
  logic [w_cnt_w-1:0] w_cnt;
  logic [dim_w-1:0]   h_cnt;
  logic [dim_w:0]     width_use;
  logic [w_cnt_w-1:0] blk_num;
  logic               slice_end;

  // ==============================
  // width blocks per line
  // ==============================
  // width field is pixels minus one
  assign width_use = {1'b0, width} + 1'b1;
  // round up to whole blocks
  assign blk_num = width_use[dim_w:w_block_atoms_log2]
                 + w_cnt_w'(|width_use[w_block_atoms_log2-1:0]);

  // position flags
  assign pos.last_c   = (c_cnt == channel[dim_w-1:atom_bytes_log2]);
  assign pos.last_w   = (w_cnt == blk_num - 1'b1);
  assign pos.last_h   = (h_cnt == height);
  assign slice_end    = pos.last_c & pos.last_w;
  assign pos.cube_end = slice_end & pos.last_h;

  // full block except the tail, a single block is the tail
  assign pos.blk_size = pos.last_w ? width[w_block_atoms_log2-1:0] : '1;

  // ==============================
  // counters
  // ==============================
  // channel groups innermost
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      c_cnt <= '0;
    end else if (accept) begin
      c_cnt <= pos.last_c ? '0 : c_cnt + 1'b1;
    end
  end

  // width block steps after all channel groups
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      w_cnt <= '0;
    end else if (accept) begin
      if (slice_end) begin
        w_cnt <= '0;
      end else if (pos.last_c) begin
        w_cnt <= w_cnt + 1'b1;
      end
    end
  end

  // line steps at slice end
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      h_cnt <= '0;
    end else if (accept) begin
      if (pos.cube_end) begin
        h_cnt <= '0;
      end else if (slice_end) begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  // block counter stays inside the line
  a_w_cnt_range: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    w_cnt < blk_num
  );

endmodule

/* source/cdp_rdma_op_ctrl.sv */
// layer control FSM
`timescale 1ns/10ps

module cdp_rdma_op_ctrl (
  input  logic         nvdla_core_clk,
  input  logic         nvdla_core_rstn,
  input  logic         op_en,
  input  logic         eg2ig_done,
  input  logic         dma_ready,
  input  logic         cq_ready,
  cdp_rdma_pos_if.user pos,
  output logic         dma_valid,
  output logic         cq_valid,
  output logic         accept,
  output logic         load,
  output logic         layer_done
);
  import cdp_rdma_types_pkg::*;

  op_state_e state;
  op_state_e state_nxt;
  logic      running;

  // ==============================
  // state register
  // ==============================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      state <= op_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      // start on op_en level
      op_idle: if (op_en) state_nxt = op_run;
      // last request of the cube accepted
      op_run: if (layer_done) state_nxt = op_drain;
      // hold off next layer until egress is done
      op_drain: if (eg2ig_done) state_nxt = op_idle;
      default: state_nxt = op_idle;
    endcase
  end

  // ==============================
  // joint handshake
  // ==============================
  assign running = (state == op_run);
  // each valid gated by the other side's ready
  assign dma_valid = running & cq_ready;
  assign cq_valid  = running & dma_ready;
  assign accept    = dma_valid & dma_ready;

  // reload addresses whenever not issuing
  assign load       = op_en & ~running;
  assign layer_done = accept & pos.cube_end;

  // no request once the cube end has gone out
  a_no_accept_after_end: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    layer_done |=> !accept
  );

endmodule

/* source/cdp_rdma_pos_if.sv */
// cube position flags
`timescale 1ns/10ps

interface cdp_rdma_pos_if;

  // last channel group, width block, line
  logic last_c;
  logic last_w;
  logic last_h;
  // all three at once
  logic cube_end;
  // atoms in current block minus one
  logic [cdp_rdma_cfg_pkg::w_block_atoms_log2-1:0] blk_size;

  // driven by the walker
  modport walker (
    output last_c, last_w, last_h, cube_end, blk_size
  );

  // read by control, address and top
  modport user (
    input last_c, last_w, last_h, cube_end, blk_size
  );

endinterface

/* source/cdp_rdma_types_pkg.sv */
// read dma ingress types

package cdp_rdma_types_pkg;

  // ==============================
  // layer control
  // ==============================
  // idle, issuing, waiting for egress done
  typedef enum logic [1:0] {
    op_idle  = 2'd0,
    op_run   = 2'd1,
    op_drain = 2'd2
  } op_state_e;

  // ==============================
  // payloads
  // ==============================
  // dma read request, size above address
  typedef struct packed {
    logic [cdp_rdma_cfg_pkg::size_w-1:0] size;
    logic [cdp_rdma_cfg_pkg::addr_w-1:0] addr;
  } dma_req_t;

  // context queue entry for the egress side
  typedef struct packed {
    logic                                            last_c;
    logic                                            last_h;
    logic                                            last_w;
    logic                                            align;
    logic [cdp_rdma_cfg_pkg::w_block_atoms_log2-1:0] size;
  } cq_entry_t;

endpackage

/* source/cdp_rdma_cfg_pkg.sv */
// read dma ingress sizing constants

package cdp_rdma_cfg_pkg;

  // ==============================
  // memory atom and width block
  // ==============================
  // one atom is 32 bytes
  localparam int atom_bytes_log2 = 5;
  // up to eight atoms per width block
  localparam int w_block_atoms_log2 = 3;

  // ==============================
  // request payload
  // ==============================
  localparam int addr_w = 64;
  // size field holds atoms minus one
  localparam int size_w = 15;

  // ==============================
  // cube dimensions and counters
  // ==============================
  // register-side width, height, channel
  localparam int dim_w = 13;
  // width block counter, enough for (8191+1)/8 blocks
  localparam int w_cnt_w = 11;
  // channel group counter, channel bits above the atom
  localparam int c_cnt_w = dim_w - atom_bytes_log2;

  // stall counter and perf registers
  localparam int stall_w = 32;

endpackage
